// ==== common/load_cache_pkg.sv ====
package load_cache_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // One data word is 32 bits, four bytes
    localparam int DATA_W         = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_SEL_W     = $clog2(BYTES_PER_WORD);

    // A line holds four words
    localparam int LINE_WORDS = 4;
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);

    localparam int TAG_W   = 20;
    localparam int INDEX_W = 8;

    // ----------------------------------------
    // Address and load operation
    // ----------------------------------------

    // Tag, index, word and byte fields together make exactly one word
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word_sel;
        logic [BYTE_SEL_W-1:0] byte_sel;
    } load_addr_t;

    typedef enum logic [1:0] {
        LDB,
        LDH,
        LDW
    } load_opcode_t;

    typedef struct packed {
        load_opcode_t opcode;
        logic         signed_load;
    } load_op_t;

    typedef struct packed {
        load_addr_t address;
        load_op_t   op;
    } load_req_t;

    // The same word seen whole or as four bytes, byte 0 in the low bits
    typedef union packed {
        logic [DATA_W-1:0]                word;
        logic [BYTES_PER_WORD-1:0][7:0]   bytes;
    } data_word_t;

    // ----------------------------------------
    // Cache and store buffer ports
    // ----------------------------------------

    // Setting dirty_en makes the cache also return the line dirty bit
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word_sel;
        logic                  dirty_en;
    } cache_rd_t;

    // With alloc_tag the cache also writes the tag and marks the line valid and clean
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word_sel;
        data_word_t            data;
        logic                  alloc_tag;
    } cache_wr_t;

    // Writeback is always a full word, so byte_sel stays zero
    typedef struct packed {
        load_addr_t address;
        data_word_t data;
    } wb_packet_t;

endpackage

// ==== hw/load_data_slicer.sv ====
`timescale 1ns/1ps

module load_data_slicer (
    input  load_cache_pkg::load_op_t                    op_i,
    input  logic [load_cache_pkg::BYTE_SEL_W-1:0]       byte_sel_i,
    input  load_cache_pkg::data_word_t                  word_i,
    output load_cache_pkg::data_word_t                  data_o
);

    localparam int DW = load_cache_pkg::DATA_W;

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // Byte picked through the byte view of the word
    assign byte_val = word_i.bytes[byte_sel_i];

    // Half words are aligned, so only byte_sel bit 1 matters
    assign half_val = {word_i.bytes[{byte_sel_i[1], 1'b1}],
                       word_i.bytes[{byte_sel_i[1], 1'b0}]};

    always_comb begin
        case (op_i.opcode)
            load_cache_pkg::LDB: begin
                // Upper bits copy the sign bit only for signed loads
                data_o.word = {{(DW - 8){op_i.signed_load & byte_val[7]}}, byte_val};
            end
            load_cache_pkg::LDH: begin
                data_o.word = {{(DW - 16){op_i.signed_load & half_val[15]}}, half_val};
            end
            default: begin
                // Full word, no extension needed
                data_o = word_i;
            end
        endcase
    end

endmodule

// ==== line_refill/line_fill_buffer.sv ====
`timescale 1ns/1ps

module line_fill_buffer (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  rsp_valid_i,
    input  load_cache_pkg::data_word_t            rsp_data_i,
    input  logic                                  clear_i,
    input  logic [load_cache_pkg::WORD_SEL_W-1:0] rd_index_i,
    input  logic [load_cache_pkg::WORD_SEL_W-1:0] word_sel_i,
    output logic [load_cache_pkg::WORD_SEL_W:0]   count_o,
    output load_cache_pkg::data_word_t            word_o,
    output load_cache_pkg::data_word_t            req_word_o
);

    localparam int SEL_W = load_cache_pkg::WORD_SEL_W;

    load_cache_pkg::data_word_t line_q [load_cache_pkg::LINE_WORDS];
    load_cache_pkg::data_word_t req_word_q;
    logic [SEL_W:0]             count_q;
    logic                       capture;

    // Words arrive in line order, so the count is also the write slot
    assign capture = rsp_valid_i && !clear_i && (count_q < load_cache_pkg::LINE_WORDS);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            count_q <= '0;
        end else if (capture) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            line_q[count_q[SEL_W-1:0]] <= rsp_data_i;
            // Keep the word the load asked for
            if (count_q[SEL_W-1:0] == word_sel_i) begin
                req_word_q <= rsp_data_i;
            end
        end
    end

    assign count_o    = count_q;
    assign word_o     = line_q[rd_index_i];
    assign req_word_o = req_word_q;

endmodule

// ==== line_refill/line_refill_engine.sv ====
`timescale 1ns/1ps

module line_refill_engine (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        start_i,
    input  load_cache_pkg::load_req_t   req_i,
    output logic                        busy_o,
    output logic                        done_o,
    output load_cache_pkg::data_word_t  word_o,
    output logic                        rd_en_o,
    output load_cache_pkg::cache_rd_t   rd_o,
    input  load_cache_pkg::data_word_t  cache_rd_data_i,
    input  logic                        cache_dirty_i,
    output logic                        wb_valid_o,
    output load_cache_pkg::wb_packet_t  wb_o,
    input  logic                        wb_ready_i,
    output logic                        mem_req_valid_o,
    output load_cache_pkg::load_addr_t  mem_req_addr_o,
    input  logic                        mem_req_ready_i,
    input  logic                        mem_rsp_valid_i,
    input  load_cache_pkg::data_word_t  mem_rsp_data_i,
    output logic                        cache_wr_valid_o,
    output load_cache_pkg::cache_wr_t   cache_wr_o,
    input  logic                        cache_wr_ready_i
);

    localparam int               SEL_W     = load_cache_pkg::WORD_SEL_W;
    localparam int               CNT_W     = SEL_W + 1;
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(load_cache_pkg::LINE_WORDS - 1);

    typedef enum logic [2:0] {
        IDLE,
        READ_VICTIM,
        DIRTY_CHECK,
        WRITE_BACK,
        MEM_REQUEST,
        ALLOCATE,
        DONE
    } refill_state_t;

    refill_state_t              state_q;
    refill_state_t              state_d;
    logic [CNT_W-1:0]           wr_cnt_q;
    logic [CNT_W-1:0]           wr_cnt_d;
    logic [SEL_W-1:0]           word_idx;
    logic                       rd_valid_q;
    load_cache_pkg::load_addr_t addr_q;
    load_cache_pkg::data_word_t victim_q;
    logic                       fill_clear;
    logic [CNT_W-1:0]           fill_count;
    load_cache_pkg::data_word_t fill_word;

    // One counter serves as the victim word index, then as the written word count
    assign word_idx = wr_cnt_q[SEL_W-1:0];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            wr_cnt_q   <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            wr_cnt_q   <= wr_cnt_d;
            rd_valid_q <= rd_en_o;
        end
    end

    // Victim data is valid only one cycle after the read, keep it for a stalled push
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && start_i) begin
            addr_q <= req_i.address;
        end
        if (rd_valid_q) begin
            victim_q <= cache_rd_data_i;
        end
    end

    always_comb begin
        state_d  = state_q;
        wr_cnt_d = wr_cnt_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d  = READ_VICTIM;
                    wr_cnt_d = '0;
                end
            end
            READ_VICTIM: begin
                // Word 0 comes back together with the dirty bit
                state_d = (wr_cnt_q == '0) ? DIRTY_CHECK : WRITE_BACK;
            end
            DIRTY_CHECK: begin
                // Clean line goes straight to memory
                if (!cache_dirty_i) begin
                    state_d = MEM_REQUEST;
                end else if (wb_ready_i) begin
                    state_d  = READ_VICTIM;
                    wr_cnt_d = wr_cnt_q + 1'b1;
                end else begin
                    state_d = WRITE_BACK;
                end
            end
            WRITE_BACK: begin
                if (wb_ready_i) begin
                    if (wr_cnt_q == LAST_WORD) begin
                        state_d = MEM_REQUEST;
                    end else begin
                        state_d  = READ_VICTIM;
                        wr_cnt_d = wr_cnt_q + 1'b1;
                    end
                end
            end
            MEM_REQUEST: begin
                if (mem_req_ready_i) begin
                    state_d  = ALLOCATE;
                    wr_cnt_d = '0;
                end
            end
            ALLOCATE: begin
                if (cache_wr_valid_o && cache_wr_ready_i) begin
                    wr_cnt_d = wr_cnt_q + 1'b1;
                    if (wr_cnt_q == LAST_WORD) begin
                        state_d = DONE;
                    end
                end
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);

    // ----------------------------------------
    // Victim read and writeback
    // ----------------------------------------

    assign rd_en_o = (state_q == READ_VICTIM);
    assign rd_o    = '{tag:      addr_q.tag,
                       index:    addr_q.index,
                       word_sel: word_idx,
                       dirty_en: (wr_cnt_q == '0)};

    assign wb_valid_o = ((state_q == DIRTY_CHECK) && cache_dirty_i) || (state_q == WRITE_BACK);
    assign wb_o       = '{address: '{addr_q.tag, addr_q.index, word_idx, '0},
                          data:    rd_valid_q ? cache_rd_data_i : victim_q};

    // ----------------------------------------
    // Memory request and allocation
    // ----------------------------------------

    assign mem_req_valid_o = (state_q == MEM_REQUEST);
    assign mem_req_addr_o  = '{addr_q.tag, addr_q.index, '0, '0};

    // Write as soon as more words have arrived than have been written
    assign cache_wr_valid_o = (state_q == ALLOCATE) && (wr_cnt_q < fill_count);
    assign cache_wr_o       = '{tag:       addr_q.tag,
                                index:     addr_q.index,
                                word_sel:  word_idx,
                                data:      fill_word,
                                alloc_tag: (wr_cnt_q == '0)};

    assign fill_clear = (state_q == IDLE) && start_i;

    line_fill_buffer u_fill (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rsp_valid_i (mem_rsp_valid_i),
        .rsp_data_i  (mem_rsp_data_i),
        .clear_i     (fill_clear),
        .rd_index_i  (word_idx),
        .word_sel_i  (addr_q.word_sel),
        .count_o     (fill_count),
        .word_o      (fill_word),
        .req_word_o  (word_o)
    );

endmodule

// ==== hw/load_lookup_fsm.sv ====
`timescale 1ns/1ps

module load_lookup_fsm (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        req_valid_i,
    input  load_cache_pkg::load_req_t   req_i,
    output logic                        req_ready_o,
    output logic                        data_valid_o,
    input  logic                        data_ready_i,
    output logic                        cache_rd_en_o,
    output load_cache_pkg::cache_rd_t   cache_rd_o,
    input  load_cache_pkg::data_word_t  cache_rd_data_i,
    input  logic                        cache_hit_i,
    output logic                        refill_start_o,
    input  logic                        refill_busy_i,
    input  logic                        refill_done_i,
    input  load_cache_pkg::data_word_t  refill_word_i,
    input  logic                        refill_rd_en_i,
    input  load_cache_pkg::cache_rd_t   refill_rd_i,
    output load_cache_pkg::load_req_t   req_q_o,
    output load_cache_pkg::data_word_t  raw_word_o
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESULT
    } lookup_state_t;

    lookup_state_t              state_q;
    lookup_state_t              state_d;
    load_cache_pkg::load_req_t  req_q;
    load_cache_pkg::data_word_t word_q;
    logic                       hit;

    // Cache answer is valid in LOOKUP, the cycle after the strobe
    assign hit = (state_q == LOOKUP) && cache_hit_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request and unsliced word registers
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
        if (hit) begin
            word_q <= cache_rd_data_i;
        end else if ((state_q == REFILL) && refill_done_i) begin
            word_q <= refill_word_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                // A hit taken at once goes straight back to IDLE
                if (!cache_hit_i) begin
                    state_d = REFILL;
                end else if (data_ready_i) begin
                    state_d = IDLE;
                end else begin
                    state_d = RESULT;
                end
            end
            REFILL: begin
                if (refill_done_i) begin
                    state_d = RESULT;
                end
            end
            RESULT: begin
                if (data_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign req_ready_o    = (state_q == IDLE);
    assign data_valid_o   = hit || (state_q == RESULT);
    assign refill_start_o = (state_q == LOOKUP) && !cache_hit_i;
    assign req_q_o        = req_q;

    // On a hit the word goes out directly from the cache
    assign raw_word_o = (state_q == LOOKUP) ? cache_rd_data_i : word_q;

    // ----------------------------------------
    // Cache read port
    // ----------------------------------------

    // During a refill the engine drives the port, otherwise incoming requests do
    always_comb begin
        if (state_q == REFILL) begin
            cache_rd_en_o = refill_busy_i && refill_rd_en_i;
            cache_rd_o    = refill_rd_i;
        end else begin
            cache_rd_en_o = (state_q == IDLE) && req_valid_i;
            cache_rd_o    = '{tag:      req_i.address.tag,
                              index:    req_i.address.index,
                              word_sel: req_i.address.word_sel,
                              dirty_en: 1'b0};
        end
    end

endmodule

// ==== hw/load_cache_controller.sv ====
`timescale 1ns/1ps

module load_cache_controller (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // Load request channel
    input  logic                        req_valid_i,
    input  load_cache_pkg::load_req_t   req_i,
    output logic                        req_ready_o,

    // Load result channel
    output logic                        data_valid_o,
    output load_cache_pkg::data_word_t  data_o,
    input  logic                        data_ready_i,

    // Cache read port, answered one cycle after the strobe
    output logic                        cache_rd_en_o,
    output load_cache_pkg::cache_rd_t   cache_rd_o,
    input  load_cache_pkg::data_word_t  cache_rd_data_i,
    input  logic                        cache_hit_i,
    input  logic                        cache_dirty_i,

    // Cache write port
    output logic                        cache_wr_valid_o,
    output load_cache_pkg::cache_wr_t   cache_wr_o,
    input  logic                        cache_wr_ready_i,

    // External memory
    output logic                        mem_req_valid_o,
    output load_cache_pkg::load_addr_t  mem_req_addr_o,
    input  logic                        mem_req_ready_i,
    input  logic                        mem_rsp_valid_i,
    input  load_cache_pkg::data_word_t  mem_rsp_data_i,

    // Store buffer writeback
    output logic                        wb_valid_o,
    output load_cache_pkg::wb_packet_t  wb_o,
    input  logic                        wb_ready_i
);

    logic                       refill_start;
    logic                       refill_busy;
    logic                       refill_done;
    load_cache_pkg::data_word_t refill_word;
    logic                       refill_rd_en;
    load_cache_pkg::cache_rd_t  refill_rd;
    load_cache_pkg::load_req_t  req_q;
    load_cache_pkg::data_word_t raw_word;

    // Request handling and ownership of the cache read port
    load_lookup_fsm u_lookup (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .data_valid_o    (data_valid_o),
        .data_ready_i    (data_ready_i),
        .cache_rd_en_o   (cache_rd_en_o),
        .cache_rd_o      (cache_rd_o),
        .cache_rd_data_i (cache_rd_data_i),
        .cache_hit_i     (cache_hit_i),
        .refill_start_o  (refill_start),
        .refill_busy_i   (refill_busy),
        .refill_done_i   (refill_done),
        .refill_word_i   (refill_word),
        .refill_rd_en_i  (refill_rd_en),
        .refill_rd_i     (refill_rd),
        .req_q_o         (req_q),
        .raw_word_o      (raw_word)
    );

    // The result is sliced after the hold register, so it stays stable under back-pressure
    load_data_slicer u_slicer (
        .op_i       (req_q.op),
        .byte_sel_i (req_q.address.byte_sel),
        .word_i     (raw_word),
        .data_o     (data_o)
    );

    // Miss handling: writeback, memory request and line allocation
    line_refill_engine u_refill (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .start_i          (refill_start),
        .req_i            (req_q),
        .busy_o           (refill_busy),
        .done_o           (refill_done),
        .word_o           (refill_word),
        .rd_en_o          (refill_rd_en),
        .rd_o             (refill_rd),
        .cache_rd_data_i  (cache_rd_data_i),
        .cache_dirty_i    (cache_dirty_i),
        .wb_valid_o       (wb_valid_o),
        .wb_o             (wb_o),
        .wb_ready_i       (wb_ready_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_data_i   (mem_rsp_data_i),
        .cache_wr_valid_o (cache_wr_valid_o),
        .cache_wr_o       (cache_wr_o),
        .cache_wr_ready_i (cache_wr_ready_i)
    );

endmodule

// ==== bench/tb_load_cache_controller.sv ====
`timescale 1ns/1ps

module tb_load_cache_controller;

    localparam int NFIELD  = 15;
    localparam int MAX_VEC = 32;

    logic                       clk_i = 1'b0;
    logic                       rst_n_i;
    logic                       req_valid_i;
    load_cache_pkg::load_req_t  req_i;
    logic                       req_ready_o;
    logic                       data_valid_o;
    load_cache_pkg::data_word_t data_o;
    logic                       data_ready_i;
    logic                       cache_rd_en_o;
    load_cache_pkg::cache_rd_t  cache_rd_o;
    load_cache_pkg::data_word_t cache_rd_data_i;
    logic                       cache_hit_i;
    logic                       cache_dirty_i;
    logic                       cache_wr_valid_o;
    load_cache_pkg::cache_wr_t  cache_wr_o;
    logic                       cache_wr_ready_i;
    logic                       mem_req_valid_o;
    load_cache_pkg::load_addr_t mem_req_addr_o;
    logic                       mem_req_ready_i;
    logic                       mem_rsp_valid_i;
    load_cache_pkg::data_word_t mem_rsp_data_i;
    logic                       wb_valid_o;
    load_cache_pkg::wb_packet_t wb_o;
    logic                       wb_ready_i;

    // Columns: 0 op, 1 signed, 2 addr, 3 hit, 4 dirty, 5 hit word,
    // 6..9 victim words, 10..13 memory words, 14 expected data
    logic [31:0] vec [MAX_VEC][NFIELD];
    int          n_vec  = 0;
    int          errors = 0;
    logic        vectors_loaded = 1'b0;

    load_cache_controller DUT (.*);

    always #10 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at t=%0t: %s", $time, what);
    endtask

    // The random mix keeps every ready input toggling
    task automatic randomize_ready();
        data_ready_i     = ($urandom % 4) != 0;
        wb_ready_i       = ($urandom % 3) != 0;
        cache_wr_ready_i = ($urandom % 3) != 0;
        mem_req_ready_i  = ($urandom % 2) != 0;
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f [NFIELD];
        fd = $fopen("bench/load_cache_golden.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open the golden vector file");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                code = $fgets(line, fd);
                // Lines starting with # describe the columns
                if (code > 0 && line.len() > 1 && line[0] != 8'h23) begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                   f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                    if (code == NFIELD) begin
                        for (int i = 0; i < NFIELD; i++) begin
                            vec[n_vec][i] = f[i];
                        end
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // One load with cache, memory and store buffer models
    // ----------------------------------------

    task automatic run_vector(input int v);
        logic [31:0] addr;
        logic [31:0] exp;
        logic [31:0] hold_val;
        logic        hit;
        logic        dirty;
        logic        accepted;
        logic        pend;
        logic        pend_dirty_en;
        logic        holding;
        logic        done;
        logic        mem_on;
        logic [1:0]  pend_sel;
        int          cyc;
        int          acc_cyc;
        int          rd_cnt;
        int          wb_cnt;
        int          wr_cnt;
        int          mreq_cnt;
        int          mem_sent;
        addr = vec[v][2];
        exp = vec[v][14];
        hit = vec[v][3][0];
        dirty = vec[v][4][0];
        {accepted, pend, holding, done, mem_on} = '0;
        {cyc, acc_cyc, rd_cnt, wb_cnt, wr_cnt, mreq_cnt, mem_sent} = '0;
        pend_sel = '0;
        pend_dirty_en = 1'b0;
        hold_val = '0;
        req_i.address = load_cache_pkg::load_addr_t'(addr);
        req_i.op.opcode = load_cache_pkg::load_opcode_t'(vec[v][0][1:0]);
        req_i.op.signed_load = vec[v][1][0];
        req_valid_i = 1'b1;
        while (!done) begin
            // Outputs are sampled mid-cycle where they are settled
            @(negedge clk_i);
            cyc++;
            pend = cache_rd_en_o;
            pend_sel = cache_rd_o.word_sel;
            pend_dirty_en = cache_rd_o.dirty_en;
            // The previous result was taken, so a new request is accepted at once
            if (cyc == 1) begin
                check_value("req_ready_o", 1, 32'(req_ready_o));
            end
            if (cache_rd_en_o) begin
                check_value("cache_rd_o tag and index", 32'(addr[31:4]),
                            32'({cache_rd_o.tag, cache_rd_o.index}));
                // The lookup reads the requested word itself
                if (rd_cnt == 0) begin
                    check_value("cache_rd_o.word_sel", 32'(addr[3:2]),
                                32'(cache_rd_o.word_sel));
                end
            end
            if (req_valid_i && req_ready_o) begin
                accepted = 1'b1;
                acc_cyc = cyc;
            end
            if (wb_valid_o && wb_ready_i) begin
                if (hit || !dirty || wb_cnt >= 4) begin
                    report_failure("unexpected writeback packet");
                end else begin
                    check_value("wb_o.address", {addr[31:4], 2'(wb_cnt), 2'b00}, wb_o.address);
                    check_value("wb_o.data", vec[v][6 + wb_cnt], wb_o.data.word);
                end
                wb_cnt++;
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                check_value("mem_req_addr_o", {addr[31:4], 4'h0}, mem_req_addr_o);
                mreq_cnt++;
                mem_on = 1'b1;
            end
            if (cache_wr_valid_o && cache_wr_ready_i) begin
                if (hit || wr_cnt >= 4) begin
                    report_failure("unexpected cache write");
                end else begin
                    check_value("cache_wr_o tag and index", 32'(addr[31:4]),
                                32'({cache_wr_o.tag, cache_wr_o.index}));
                    check_value("cache_wr_o.word_sel", 32'(wr_cnt), 32'(cache_wr_o.word_sel));
                    check_value("cache_wr_o.data", vec[v][10 + wr_cnt], cache_wr_o.data.word);
                    check_value("cache_wr_o.alloc_tag", 32'(wr_cnt == 0),
                                32'(cache_wr_o.alloc_tag));
                end
                wr_cnt++;
            end
            if (data_valid_o) begin
                if (!holding && hit) begin
                    check_value("data_valid_o cycle", 32'(acc_cyc + 1), 32'(cyc));
                end
                if (holding) begin
                    check_value("data_o held", hold_val, data_o.word);
                end
                check_value("data_o", exp, data_o.word);
                check_value("req_ready_o", 0, 32'(req_ready_o));
                holding = 1'b1;
                hold_val = data_o.word;
                done = data_ready_i;
            end
            @(posedge clk_i);
            #1;
            if (accepted) begin
                req_valid_i = 1'b0;
            end
            // The first read is the lookup, later ones fetch victim words
            if (pend) begin
                cache_hit_i = (rd_cnt == 0) ? hit : 1'b0;
                // The dirty bit comes back only when the read asks for it
                cache_dirty_i = pend_dirty_en ? dirty : 1'b0;
                cache_rd_data_i = (rd_cnt == 0) ? vec[v][5] : vec[v][6 + pend_sel];
                rd_cnt++;
            end
            mem_rsp_valid_i = 1'b0;
            if (mem_on && mem_sent < 4 && ($urandom % 3) != 0) begin
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i = vec[v][10 + mem_sent];
                mem_sent++;
            end
            randomize_ready();
        end
        check_value("writeback count", (!hit && dirty) ? 32'd4 : 32'd0, 32'(wb_cnt));
        check_value("memory request count", hit ? 32'd0 : 32'd1, 32'(mreq_cnt));
        check_value("cache write count", hit ? 32'd0 : 32'd4, 32'(wr_cnt));
    endtask

    task automatic check_idle_outputs();
        check_value("data_valid_o", 0, 32'(data_valid_o));
        check_value("cache_rd_en_o", 0, 32'(cache_rd_en_o));
        check_value("cache_wr_valid_o", 0, 32'(cache_wr_valid_o));
        check_value("mem_req_valid_o", 0, 32'(mem_req_valid_o));
        check_value("wb_valid_o", 0, 32'(wb_valid_o));
        check_value("req_ready_o", 1, 32'(req_ready_o));
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial begin
        void'($urandom(32'ha00fbf3e));
        rst_n_i = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        data_ready_i = 1'b0;
        cache_rd_data_i = '0;
        cache_hit_i = 1'b0;
        cache_dirty_i = 1'b0;
        cache_wr_ready_i = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i = '0;
        wb_ready_i = 1'b0;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (16) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_idle_outputs();
        @(posedge clk_i);
        #1;
        randomize_ready();
        if (n_vec == 0) begin
            report_failure("no test vectors were read");
        end
        for (int v = 0; v < n_vec; v++) begin
            run_vector(v);
        end
        $display("Vectors run: %0d, errors: %0d", n_vec, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Each vector gets 200 cycles, which covers the slowest miss
    initial begin
        wait (vectors_loaded && n_vec > 0);
        repeat (n_vec * 200 + 40) @(posedge clk_i);
        $display("Timeout: the vectors did not complete in time, errors so far: %0d", errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== bench/load_cache_golden.txt ====
# op(0 LDB 1 LDH 2 LDW) signed addr hit dirty hit_word victim0..3 mem0..3 expected
# all values hex, one load per line
2 0 00001000 1 0 12345678 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 12345678
0 1 00002001 1 0 a5b6c7d8 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 ffffffc7
0 0 00002003 1 0 a5b6c7d8 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000000a5
1 1 00003002 1 0 80017fff 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 ffff8001
1 0 00003000 1 0 80017fff 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00007fff
1 1 00003000 1 0 1234f00d 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 fffff00d
2 0 0abcd124 0 0 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 11111111 22222222 33333333 44444444 22222222
2 0 0abcd12c 0 1 00000000 aaaa0000 aaaa1111 aaaa2222 aaaa3333 55550000 55551111 55552222 55553333 55553333
0 1 12345f05 0 1 00000000 b0b0b0b0 b1b1b1b1 b2b2b2b2 b3b3b3b3 01020304 00ff8000 0a0b0c0d 0e0f1011 ffffff80
1 0 fffff0f2 0 0 00000000 c0c0c0c0 c1c1c1c1 c2c2c2c2 c3c3c3c3 9abc1234 00000001 00000002 00000003 00009abc
1 1 00040038 0 1 00000000 d0d0d0d0 d1d1d1d1 d2d2d2d2 d3d3d3d3 10000000 20000000 0000c001 40000000 ffffc001
0 0 00040033 0 0 00000000 e0e0e0e0 e1e1e1e1 e2e2e2e2 e3e3e3e3 fe000000 00000011 00000022 00000033 000000fe
0 1 00050000 1 0 0000007f 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000007f
2 0 00060008 0 1 00000000 f0f0f0f0 f1f1f1f1 f2f2f2f2 f3f3f3f3 01010101 02020202 deadbeef 04040404 deadbeef

// ==== flist.f ====
common/load_cache_pkg.sv
hw/load_data_slicer.sv
line_refill/line_fill_buffer.sv
line_refill/line_refill_engine.sv
hw/load_lookup_fsm.sv
hw/load_cache_controller.sv
bench/tb_load_cache_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the load cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_load_cache_controller \
    -f flist.f -o sim_load_cache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_load_cache > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation run returned an error status"
    cat sim.log
    exit 1
fi
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0
